// ==== common/sample_path_defines.svh ====
`ifndef SAMPLE_PATH_DEFINES_SVH
`define SAMPLE_PATH_DEFINES_SVH

// one IQ sample, 16 bit I and 16 bit Q
`define SAMPLE_W 32
`define OP_W 2
// log2 of FIFO depth
`define FIFO_SIZE 9
`define PKT_LEN_W 12

`endif

// ==== common/stream_pkg.sv ====
`include "sample_path_defines.svh"

package stream_pkg;

   // one I or Q component
   typedef logic signed [`SAMPLE_W/2-1:0] iq_t;

   // packed complex sample, I in the upper half and Q in the lower half
   typedef logic [`SAMPLE_W-1:0] sample_t;

   typedef enum logic [`OP_W-1:0] {
      OP_PASS = 2'd0,
      OP_CONJ = 2'd1,
      OP_SWAP = 2'd2,
      OP_NEG  = 2'd3
   } iq_op_e;

   function automatic iq_t sample_i(input sample_t s);
      return iq_t'(s[`SAMPLE_W-1:`SAMPLE_W/2]);
   endfunction

   function automatic iq_t sample_q(input sample_t s);
      return iq_t'(s[`SAMPLE_W/2-1:0]);
   endfunction

   function automatic sample_t make_sample(input iq_t i_part, input iq_t q_part);
      return {i_part, q_part};
   endfunction

endpackage

// ==== common/ctrl_pkg.sv ====
package ctrl_pkg;

   // read side of the block-RAM FIFO
   // RD_EMPTY    nothing in the RAM
   // RD_PRE_READ first word is being fetched
   // RD_READING  RAM read data holds the next word
   typedef enum logic [1:0] {
      RD_EMPTY    = 2'd0,
      RD_PRE_READ = 2'd1,
      RD_READING  = 2'd2
   } rd_state_e;

endpackage

// ==== fifo/dpram.sv ====
`timescale 1ns/1ns

module dpram #(
   parameter int DATA_W = 32,
   parameter int ADDR_W = 9
) (
   input  logic              clk,
   input  logic              i_wr_en,
   input  logic [ADDR_W-1:0] i_wr_addr,
   input  logic [DATA_W-1:0] i_wr_data,
   input  logic              i_rd_en,
   input  logic [ADDR_W-1:0] i_rd_addr,
   output logic [DATA_W-1:0] o_rd_data
);

   logic [DATA_W-1:0] mem [0:(1<<ADDR_W)-1];

   always_ff @(posedge clk)
   begin
      if (i_wr_en)
         mem[i_wr_addr] <= i_wr_data;
   end

   // read register only moves when enabled, so a prefetched word survives a stall
   always_ff @(posedge clk)
   begin
      if (i_rd_en)
      begin
         // write-first on an address collision
         if (i_wr_en && (i_wr_addr == i_rd_addr))
            o_rd_data <= i_wr_data;
         else
            o_rd_data <= mem[i_rd_addr];
      end
   end

endmodule

// ==== fifo/axi_fifo_bram.sv ====
`timescale 1ns/1ns

module axi_fifo_bram #(
   parameter int WIDTH = 32,
   parameter int SIZE  = 9
) (
   input  logic             clk,
   input  logic             reset,
   input  logic             i_clear,
   input  logic [WIDTH-1:0] i_tdata,
   input  logic             i_tvalid,
   output logic             o_tready,
   output logic [WIDTH-1:0] o_tdata,
   output logic             o_tvalid,
   input  logic             i_tready,
   output logic [15:0]      o_occupied
);

   logic [SIZE-1:0]     wr_addr;
   logic [SIZE-1:0]     rd_addr;
   logic [WIDTH-1:0]    ram_rd_data;
   ctrl_pkg::rd_state_e rd_state;
   logic                empty_reg;
   logic                full_reg;
   logic                write;
   logic                read;
   logic                read_int;
   logic                out_ready;
   logic                becoming_full;

   assign write = i_tvalid && o_tready;
   assign read  = o_tvalid && i_tready;
   // pull from the RAM whenever the output register can take a word
   assign out_ready = i_tready || !o_tvalid;
   assign read_int  = !empty_reg && out_ready;
   assign o_tready  = !full_reg;

   always_ff @(posedge clk)
   begin
      if (reset || i_clear)
         wr_addr <= '0;
      else if (write)
         wr_addr <= wr_addr + 1'b1;
   end

   dpram #(
      .DATA_W (WIDTH),
      .ADDR_W (SIZE)
   ) i_dpram (
      .clk       (clk),
      .i_wr_en   (write),
      .i_wr_addr (wr_addr),
      .i_wr_data (i_tdata),
      .i_rd_en   ((rd_state == ctrl_pkg::RD_PRE_READ) || read_int),
      .i_rd_addr (rd_addr),
      .o_rd_data (ram_rd_data)
   );

   // prefetch keeps the RAM read one word ahead of the output register
   always_ff @(posedge clk)
   begin
      if (reset || i_clear)
      begin
         rd_state  <= ctrl_pkg::RD_EMPTY;
         rd_addr   <= '0;
         empty_reg <= 1'b1;
      end
      else
      begin
         case (rd_state)
            ctrl_pkg::RD_EMPTY:
            begin
               if (write)
                  rd_state <= ctrl_pkg::RD_PRE_READ;
            end
            ctrl_pkg::RD_PRE_READ:
            begin
               rd_state  <= ctrl_pkg::RD_READING;
               empty_reg <= 1'b0;
               rd_addr   <= rd_addr + 1'b1;
            end
            ctrl_pkg::RD_READING:
            begin
               if (read_int)
               begin
                  if (rd_addr == wr_addr)
                  begin
                     // last word left the RAM, refetch if one just arrived
                     empty_reg <= 1'b1;
                     rd_state  <= write ? ctrl_pkg::RD_PRE_READ : ctrl_pkg::RD_EMPTY;
                  end
                  else
                     rd_addr <= rd_addr + 1'b1;
               end
            end
            default:
               rd_state <= ctrl_pkg::RD_EMPTY;
         endcase
      end
   end

   // stop two short of the read pointer
   assign becoming_full = (wr_addr == SIZE'(rd_addr - 2'd2));

   always_ff @(posedge clk)
   begin
      if (reset || i_clear)
         full_reg <= 1'b0;
      else if (read_int && !write)
         full_reg <= 1'b0;
      else if (write && !read_int && becoming_full)
         full_reg <= 1'b1;
   end

   // registered output stage
   always_ff @(posedge clk)
   begin
      if (reset || i_clear)
         o_tvalid <= 1'b0;
      else if (out_ready)
         o_tvalid <= !empty_reg;
   end

   always_ff @(posedge clk)
   begin
      if (out_ready)
         o_tdata <= ram_rd_data;
   end

   // rough occupancy for diagnostics, counted at the ports
   always_ff @(posedge clk)
   begin
      if (reset || i_clear)
         o_occupied <= 16'd0;
      else if (write && !read)
         o_occupied <= o_occupied + 16'd1;
      else if (read && !write)
         o_occupied <= o_occupied - 16'd1;
   end

   // an accepted write never takes the slot just behind the read pointer
   a_no_write_when_full: assert property (@(posedge clk) disable iff (reset || i_clear)
      write |-> (SIZE'(wr_addr + 1'b1) != rd_addr));

   a_out_hold: assert property (@(posedge clk) disable iff (reset || i_clear)
      o_tvalid && !i_tready |=> o_tvalid && $stable(o_tdata));

endmodule

// ==== verilog/iq_op_stage.sv ====
`timescale 1ns/1ns
`include "sample_path_defines.svh"

module iq_op_stage (
   input  logic                         clk,
   input  logic                         reset,
   input  logic                         i_clear,
   input  logic [`SAMPLE_W+`OP_W-1:0]   i_tdata,
   input  logic                         i_tvalid,
   output logic                         o_tready,
   output stream_pkg::sample_t          o_tdata,
   output logic                         o_tvalid,
   input  logic                         i_tready
);

   stream_pkg::iq_op_e   op;
   stream_pkg::sample_t  in_sample;
   stream_pkg::iq_t      in_i;
   stream_pkg::iq_t      in_q;
   stream_pkg::sample_t  result;

   // negation of the most negative value clips to the most positive
   function automatic stream_pkg::iq_t sat_neg(input stream_pkg::iq_t x);
      if (x == 16'sh8000)
         return 16'sh7fff;
      else
         return -x;
   endfunction

   assign op        = stream_pkg::iq_op_e'(i_tdata[`SAMPLE_W+`OP_W-1:`SAMPLE_W]);
   assign in_sample = i_tdata[`SAMPLE_W-1:0];
   assign in_i      = stream_pkg::sample_i(in_sample);
   assign in_q      = stream_pkg::sample_q(in_sample);

   always_comb
   begin
      case (op)
         stream_pkg::OP_CONJ: result = stream_pkg::make_sample(in_i, sat_neg(in_q));
         stream_pkg::OP_SWAP: result = stream_pkg::make_sample(in_q, in_i);
         stream_pkg::OP_NEG:  result = stream_pkg::make_sample(sat_neg(in_i), sat_neg(in_q));
         default:             result = in_sample;
      endcase
   end

   // no skid, stall goes straight back upstream
   assign o_tready = i_tready || !o_tvalid;

   always_ff @(posedge clk)
   begin
      if (reset || i_clear)
         o_tvalid <= 1'b0;
      else if (o_tready)
         o_tvalid <= i_tvalid;
   end

   always_ff @(posedge clk)
   begin
      if (o_tready && i_tvalid)
         o_tdata <= result;
   end

   a_stall_stable: assert property (@(posedge clk) disable iff (reset || i_clear)
      o_tvalid && !i_tready |=> o_tvalid && $stable(o_tdata));

endmodule

// ==== verilog/packet_framer.sv ====
`timescale 1ns/1ns
`include "sample_path_defines.svh"

module packet_framer (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  i_clear,
   input  stream_pkg::sample_t   i_tdata,
   input  logic                  i_tvalid,
   input  logic [`PKT_LEN_W-1:0] i_pkt_len,
   output logic                  o_tready,
   output stream_pkg::sample_t   o_tdata,
   output logic                  o_tvalid,
   output logic                  o_tlast,
   input  logic                  i_tready
);

   logic [`PKT_LEN_W-1:0] count;
   logic [`PKT_LEN_W-1:0] last_idx;
   logic                  accept;

   // zero length behaves as one
   assign last_idx = (i_pkt_len == '0) ? '0 : i_pkt_len - 1'b1;

   assign o_tdata  = i_tdata;
   assign o_tvalid = i_tvalid;
   assign o_tready = i_tready;
   assign o_tlast  = i_tvalid && (count == last_idx);
   assign accept   = i_tvalid && i_tready;

   always_ff @(posedge clk)
   begin
      if (reset || i_clear)
         count <= '0;
      else if (accept)
      begin
         if (count == last_idx)
            count <= '0;
         else
            count <= count + 1'b1;
      end
   end

   // a stalled last must still be there, with valid, on the next cycle
   a_last_with_valid: assert property (@(posedge clk) disable iff (reset || i_clear)
      o_tlast && !i_tready |=> o_tvalid && o_tlast);

endmodule

// ==== verilog/sample_path_top.sv ====
`timescale 1ns/1ns
`include "sample_path_defines.svh"

module sample_path_top (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  i_clear,
   input  stream_pkg::sample_t   i_tdata,
   input  stream_pkg::iq_op_e    i_op,
   input  logic                  i_tvalid,
   input  logic [`PKT_LEN_W-1:0] i_pkt_len,
   output logic                  o_tready,
   output stream_pkg::sample_t   o_tdata,
   output logic                  o_tlast,
   output logic                  o_tvalid,
   input  logic                  i_tready,
   output logic [15:0]           o_occupied
);

   logic [`SAMPLE_W+`OP_W-1:0] fifo_tdata;
   logic                       fifo_tvalid;
   logic                       fifo_tready;
   stream_pkg::sample_t        op_tdata;
   logic                       op_tvalid;
   logic                       op_tready;

   // opcode rides with its sample through the FIFO
   axi_fifo_bram #(
      .WIDTH (`SAMPLE_W + `OP_W),
      .SIZE  (`FIFO_SIZE)
   ) i_axi_fifo_bram (
      .clk        (clk),
      .reset      (reset),
      .i_clear    (i_clear),
      .i_tdata    ({i_op, i_tdata}),
      .i_tvalid   (i_tvalid),
      .o_tready   (o_tready),
      .o_tdata    (fifo_tdata),
      .o_tvalid   (fifo_tvalid),
      .i_tready   (fifo_tready),
      .o_occupied (o_occupied)
   );

   iq_op_stage i_iq_op_stage (
      .clk      (clk),
      .reset    (reset),
      .i_clear  (i_clear),
      .i_tdata  (fifo_tdata),
      .i_tvalid (fifo_tvalid),
      .o_tready (fifo_tready),
      .o_tdata  (op_tdata),
      .o_tvalid (op_tvalid),
      .i_tready (op_tready)
   );

   packet_framer i_packet_framer (
      .clk       (clk),
      .reset     (reset),
      .i_clear   (i_clear),
      .i_tdata   (op_tdata),
      .i_tvalid  (op_tvalid),
      .i_pkt_len (i_pkt_len),
      .o_tready  (op_tready),
      .o_tdata   (o_tdata),
      .o_tvalid  (o_tvalid),
      .o_tlast   (o_tlast),
      .i_tready  (i_tready)
   );

endmodule

// ==== dv/sample_path_tb.sv ====
`timescale 1ns/1ns
`include "sample_path_defines.svh"

module sample_path_tb;

   localparam int N_ENTRIES  = 20;
   localparam int PKT_LEN    = 5;
   localparam int FILL_MAX   = (1 << `FIFO_SIZE) + 4;
   localparam int N_STREAM_A = 2 * N_ENTRIES + 2;
   localparam int N_STREAM_C = 10;
   // all samples driven in the run with the fill test at its upper bound
   localparam int N_TOTAL    = N_STREAM_A + FILL_MAX + N_STREAM_C;
   localparam int MAX_CYCLES = 40 * N_TOTAL + 2000;

   logic                  clk;
   logic                  reset;
   logic                  i_clear;
   stream_pkg::sample_t   s_tdata;
   stream_pkg::iq_op_e    s_op;
   logic                  s_tvalid;
   logic                  s_tready;
   logic [`PKT_LEN_W-1:0] pkt_len;
   stream_pkg::sample_t   m_tdata;
   logic                  m_tlast;
   logic                  m_tvalid;
   logic                  m_tready;
   logic [15:0]           occupied;

   // three words per entry for opcode, input sample and expected sample
   logic [31:0]           golden [0:3*N_ENTRIES-1];
   stream_pkg::sample_t   exp_q [$];
   integer                seed;
   int                    stall_mode;
   int                    out_cnt;
   int                    cycles;
   int                    next_idx;
   string                 test_name;

   sample_path_top i_sample_path_top (
      .clk        (clk),
      .reset      (reset),
      .i_clear    (i_clear),
      .i_tdata    (s_tdata),
      .i_op       (s_op),
      .i_tvalid   (s_tvalid),
      .i_pkt_len  (pkt_len),
      .o_tready   (s_tready),
      .o_tdata    (m_tdata),
      .o_tlast    (m_tlast),
      .o_tvalid   (m_tvalid),
      .i_tready   (m_tready),
      .o_occupied (occupied)
   );

   initial
   begin
      clk = 1'b0;
      forever
         #2 clk = ~clk;
   end

   task automatic abort_run(input string what);
      $display("ERROR: %s", what);
      $display("RESULT: FAIL");
      $fatal(1, "run stopped at first error");
   endtask

   task automatic check_sample(input string name, input stream_pkg::sample_t exp,
                               input stream_pkg::sample_t act);
      if (exp !== act)
      begin
         $display("FAILED %s: expected %h, actual %h", name, exp, act);
         $display("RESULT: FAIL");
         $fatal(1, "sample mismatch");
      end
   endtask

   task automatic check_last(input string name, input logic exp, input logic act);
      if (exp !== act)
      begin
         $display("FAILED %s: expected %b, actual %b", name, exp, act);
         $display("RESULT: FAIL");
         $fatal(1, "flag mismatch");
      end
   endtask

   task automatic check_count(input string name, input logic [15:0] exp,
                              input logic [15:0] act);
      if (exp !== act)
      begin
         $display("FAILED %s: expected %0d, actual %0d", name, exp, act);
         $display("RESULT: FAIL");
         $fatal(1, "count mismatch");
      end
   endtask

   // put one golden entry on the input and remember its result
   task automatic offer_entry();
      @(negedge clk);
      s_op     = stream_pkg::iq_op_e'(golden[3*next_idx][1:0]);
      s_tdata  = golden[3*next_idx+1];
      s_tvalid = 1'b1;
      exp_q.push_back(golden[3*next_idx+2]);
      next_idx = (next_idx + 1) % N_ENTRIES;
   endtask

   task automatic send_stream(input int count);
      int idle;
      for (int k = 0; k < count; k++)
      begin
         offer_entry();
         do
            @(posedge clk);
         while (!s_tready);
         idle = $random(seed) & 7;
         if (idle > 4)
         begin
            @(negedge clk);
            s_tvalid = 1'b0;
            repeat (idle - 5)
               @(posedge clk);
         end
      end
      @(negedge clk);
      s_tvalid = 1'b0;
   endtask

   // offer back to back until input ready drops and leave the last offer pending
   task automatic fill_until_full();
      int accepted;
      accepted = 0;
      offer_entry();
      @(posedge clk);
      while (s_tready)
      begin
         accepted++;
         if (accepted >= FILL_MAX)
            abort_run("input ready never fell while the output was stalled");
         offer_entry();
         @(posedge clk);
      end
   endtask

   task automatic drain_outputs();
      while (exp_q.size() != 0)
         @(posedge clk);
   endtask

   // output ready is high in mode 0, random in mode 1 and low otherwise
   initial
   begin
      forever
      begin
         @(negedge clk);
         case (stall_mode)
            0: m_tready = 1'b1;
            1: m_tready = ($random(seed) & 3) != 0;
            default: m_tready = 1'b0;
         endcase
      end
   end

   initial
   begin
      stream_pkg::sample_t exp;
      forever
      begin
         @(posedge clk);
         if (m_tvalid && m_tready)
         begin
            if (exp_q.size() == 0)
               abort_run("an output sample appeared with none outstanding");
            exp = exp_q.pop_front();
            check_sample($sformatf("%s sample %0d", test_name, out_cnt), exp, m_tdata);
            check_last($sformatf("%s tlast %0d", test_name, out_cnt),
                       (out_cnt % PKT_LEN) == PKT_LEN - 1, m_tlast);
            out_cnt++;
         end
      end
   end

   initial
   begin
      cycles = 0;
      forever
      begin
         @(posedge clk);
         cycles++;
         if (cycles > MAX_CYCLES)
            abort_run("timeout, the output stalled before all samples came out");
      end
   end

   initial
   begin
      seed       = 32'h48a7;
      reset      = 1'b1;
      i_clear    = 1'b0;
      s_tdata    = '0;
      s_op       = stream_pkg::OP_PASS;
      s_tvalid   = 1'b0;
      pkt_len    = `PKT_LEN_W'(PKT_LEN);
      m_tready   = 1'b0;
      stall_mode = 0;
      out_cnt    = 0;
      next_idx   = 0;
      test_name  = "reset";
      $readmemh("dv/sample_path_golden.txt", golden);
      repeat (4)
         @(negedge clk);
      reset = 1'b0;
      @(posedge clk);
      check_last("input ready after reset", 1'b1, s_tready);
      check_last("output valid after reset", 1'b0, m_tvalid);
      check_count("occupied after reset", 16'd0, occupied);

      // all opcodes with random gaps and stalls
      test_name  = "random stream";
      stall_mode = 1;
      send_stream(N_STREAM_A);
      drain_outputs();

      // hold the output and fill the FIFO
      test_name  = "fill";
      @(posedge clk);
      stall_mode = 2;
      fill_until_full();
      stall_mode = 1;
      do
         @(posedge clk);
      while (!s_tready);
      @(negedge clk);
      s_tvalid = 1'b0;
      drain_outputs();

      // flush and start a fresh packet count
      repeat (4)
         @(negedge clk);
      i_clear = 1'b1;
      @(negedge clk);
      i_clear = 1'b0;
      out_cnt = 0;
      repeat (8)
      begin
         @(posedge clk);
         check_last("output valid after clear", 1'b0, m_tvalid);
      end
      check_count("occupied after clear", 16'd0, occupied);
      test_name = "after clear";
      send_stream(N_STREAM_C);
      drain_outputs();
      repeat (4)
         @(posedge clk);
      $display("RESULT: PASS");
      $finish;
   end

endmodule

// ==== dv/sample_path_golden.txt ====
// columns: opcode (0 pass, 1 conj, 2 swap, 3 neg), input sample {I,Q}, expected sample {I,Q}
// all values hex, one entry per line
0 12345678 12345678
1 12345678 1234a988
2 12345678 56781234
3 12345678 edcca988
1 7fff8000 7fff7fff
3 80008000 7fff7fff
3 7fff0001 8001ffff
2 80007fff 7fff8000
0 ffff0000 ffff0000
1 0000ffff 00000001
3 00000000 00000000
2 abcd0123 0123abcd
1 00008001 00007fff
3 ffff8000 00017fff
0 80008000 80008000
1 80000001 8000ffff
2 0001fffe fffe0001
3 40003000 c000d000
0 deadbeef deadbeef
1 0f0f0100 0f0fff00

// ==== files.f ====
+incdir+common
common/stream_pkg.sv
common/ctrl_pkg.sv
fifo/dpram.sv
fifo/axi_fifo_bram.sv
verilog/iq_op_stage.sv
verilog/packet_framer.sv
verilog/sample_path_top.sv
dv/sample_path_tb.sv

// ==== Bender.yml ====
package:
  name: sample_path

sources:
  - include_dirs:
      - common
    files:
      - common/stream_pkg.sv
      - common/ctrl_pkg.sv
      - fifo/dpram.sv
      - fifo/axi_fifo_bram.sv
      - verilog/iq_op_stage.sv
      - verilog/packet_framer.sv
      - verilog/sample_path_top.sv
  - target: simulation
    include_dirs:
      - common
    files:
      - dv/sample_path_tb.sv
